// ==== hdl/core_pkg.sv ====
package core_pkg;

  // Instruction word width
  localparam int INSTR_W = 32;

  // Register index
  typedef logic [4:0] reg_idx_t;

  // ALU operations
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS
  } alu_op_t;

  // Branch conditions
  typedef enum logic [1:0] {
    BR_EQ,
    BR_NE,
    BR_LT
  } branch_cond_t;

  // Major opcodes
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  // funct3 for ALU forms
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;

  // funct3 for branches
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;
  localparam logic [2:0] F3_BLT = 3'b100;

  // funct7 for register forms
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

endpackage

// ==== hdl/fetch_unit.sv ====
module fetch_unit #(
  parameter int XLEN = 64
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic [XLEN-1:0]             entry,
  input  logic                        imem_valid,
  input  logic [core_pkg::INSTR_W-1:0] imem_data,
  input  logic                        fetch_ready,
  input  logic                        flush,
  input  logic [XLEN-1:0]             flush_target,
  output logic                        imem_req,
  output logic [XLEN-1:0]             imem_addr,
  output logic                        fetch_valid,
  output logic [core_pkg::INSTR_W-1:0] fetch_instr,
  output logic [XLEN-1:0]             fetch_pc
);

  logic [XLEN-1:0]              pc;
  logic                         need_req;
  logic                         pending;
  logic                         discard;
  logic                         hold_valid;
  logic [core_pkg::INSTR_W-1:0] hold_instr;

  // PC only moves on handover, so the held word belongs to pc
  assign imem_req    = need_req;
  assign imem_addr   = pc;
  assign fetch_valid = hold_valid && fetch_ready;
  assign fetch_instr = hold_instr;
  assign fetch_pc    = pc;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc         <= entry;
      need_req   <= 1'b1;
      pending    <= 1'b0;
      discard    <= 1'b0;
      hold_valid <= 1'b0;
    end else if (flush) begin
      pc         <= flush_target;
      hold_valid <= 1'b0;
      // A response on the old path is still due, so wait for it first
      if (need_req || (pending && !imem_valid)) begin
        need_req <= 1'b0;
        pending  <= 1'b1;
        discard  <= 1'b1;
      end else begin
        need_req <= 1'b1;
        pending  <= 1'b0;
        discard  <= 1'b0;
      end
    end else begin
      if (need_req) begin
        need_req <= 1'b0;
        pending  <= 1'b1;
      end
      if (imem_valid) begin
        pending <= 1'b0;
        if (discard) begin
          discard  <= 1'b0;
          need_req <= 1'b1;
        end else begin
          hold_valid <= 1'b1;
        end
      end
      // Handover to decode, then fetch the next word
      if (fetch_valid) begin
        hold_valid <= 1'b0;
        pc         <= pc + XLEN'(4);
        need_req   <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (imem_valid && !discard) begin
      hold_instr <= imem_data;
    end
  end

endmodule

// ==== hdl/decode_unit.sv ====
module decode_unit #(
  parameter int XLEN = 64
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         fetch_valid,
  input  logic [core_pkg::INSTR_W-1:0] fetch_instr,
  input  logic [XLEN-1:0]              fetch_pc,
  input  logic                         flush,
  input  logic [XLEN-1:0]              rs1_data,
  input  logic [XLEN-1:0]              rs2_data,
  input  logic                         rs1_busy,
  input  logic                         rs2_busy,
  output logic                         fetch_ready,
  output core_pkg::reg_idx_t           rs1,
  output core_pkg::reg_idx_t           rs2,
  output logic                         set_busy,
  output core_pkg::reg_idx_t           set_rd,
  output logic                         issue_valid,
  output logic [XLEN-1:0]              issue_pc,
  output logic [XLEN-1:0]              issue_a,
  output logic [XLEN-1:0]              issue_b,
  output logic [XLEN-1:0]              issue_imm,
  output core_pkg::alu_op_t            issue_alu_op,
  output core_pkg::reg_idx_t           issue_rd,
  output logic                         issue_rd_write,
  output logic                         issue_branch,
  output logic                         issue_jal,
  output core_pkg::branch_cond_t       issue_cond
);

  logic                         buf_valid;
  logic [core_pkg::INSTR_W-1:0] buf_instr;
  logic [XLEN-1:0]              buf_pc;
  logic [6:0]                   opcode;
  logic [2:0]                   funct3;
  logic [6:0]                   funct7;
  core_pkg::reg_idx_t           rd;
  logic [XLEN-1:0]              imm_i;
  logic [XLEN-1:0]              imm_b;
  logic [XLEN-1:0]              imm_u;
  logic [XLEN-1:0]              imm_j;
  logic [XLEN-1:0]              imm_d;
  logic [XLEN-1:0]              b_d;
  core_pkg::alu_op_t            alu_op_d;
  core_pkg::branch_cond_t       cond_d;
  logic                         known;
  logic                         use_rs1;
  logic                         use_rs2;
  logic                         branch_d;
  logic                         jal_d;
  logic                         rd_write_d;
  logic                         stall;
  logic                         issue_go;

  assign opcode = buf_instr[6:0];
  assign rd     = buf_instr[11:7];
  assign funct3 = buf_instr[14:12];
  assign rs1    = buf_instr[19:15];
  assign rs2    = buf_instr[24:20];
  assign funct7 = buf_instr[31:25];

  // Sign-extended immediates
  assign imm_i = XLEN'($signed(buf_instr[31:20]));
  assign imm_b = XLEN'($signed({buf_instr[31], buf_instr[7], buf_instr[30:25],
                                buf_instr[11:8], 1'b0}));
  assign imm_u = XLEN'($signed({buf_instr[31:12], 12'b0}));
  assign imm_j = XLEN'($signed({buf_instr[31], buf_instr[19:12], buf_instr[20],
                                buf_instr[30:21], 1'b0}));

  always_comb begin
    known    = 1'b0;
    use_rs1  = 1'b0;
    use_rs2  = 1'b0;
    branch_d = 1'b0;
    jal_d    = 1'b0;
    alu_op_d = core_pkg::ALU_ADD;
    cond_d   = core_pkg::BR_EQ;
    imm_d    = imm_i;
    b_d      = rs2_data;
    case (opcode)
      core_pkg::OPC_OP_IMM: begin
        use_rs1 = 1'b1;
        b_d     = imm_i;
        known   = 1'b1;
        case (funct3)
          core_pkg::F3_ADD: alu_op_d = core_pkg::ALU_ADD;
          core_pkg::F3_XOR: alu_op_d = core_pkg::ALU_XOR;
          core_pkg::F3_OR:  alu_op_d = core_pkg::ALU_OR;
          core_pkg::F3_AND: alu_op_d = core_pkg::ALU_AND;
          default:          known    = 1'b0;
        endcase
      end
      core_pkg::OPC_OP: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        known   = 1'b1;
        if (funct7 == core_pkg::F7_SUB && funct3 == core_pkg::F3_ADD) begin
          alu_op_d = core_pkg::ALU_SUB;
        end else if (funct7 == core_pkg::F7_BASE) begin
          case (funct3)
            core_pkg::F3_ADD: alu_op_d = core_pkg::ALU_ADD;
            core_pkg::F3_SLT: alu_op_d = core_pkg::ALU_SLT;
            core_pkg::F3_XOR: alu_op_d = core_pkg::ALU_XOR;
            core_pkg::F3_OR:  alu_op_d = core_pkg::ALU_OR;
            core_pkg::F3_AND: alu_op_d = core_pkg::ALU_AND;
            default:          known    = 1'b0;
          endcase
        end else begin
          known = 1'b0;
        end
      end
      core_pkg::OPC_LUI: begin
        alu_op_d = core_pkg::ALU_PASS;
        imm_d    = imm_u;
        known    = 1'b1;
      end
      core_pkg::OPC_BRANCH: begin
        use_rs1  = 1'b1;
        use_rs2  = 1'b1;
        imm_d    = imm_b;
        branch_d = 1'b1;
        case (funct3)
          core_pkg::F3_BEQ: cond_d   = core_pkg::BR_EQ;
          core_pkg::F3_BNE: cond_d   = core_pkg::BR_NE;
          core_pkg::F3_BLT: cond_d   = core_pkg::BR_LT;
          default:          branch_d = 1'b0;
        endcase
      end
      core_pkg::OPC_JAL: begin
        imm_d = imm_j;
        jal_d = 1'b1;
        known = 1'b1;
      end
      default: begin
        known = 1'b0;
      end
    endcase
  end

  // Branches never write, anything unknown goes through as a no-op
  assign rd_write_d = known && (rd != 5'd0);

  // Hold back while a source in use is still owned by older work
  assign stall = (use_rs1 && rs1_busy) || (use_rs2 && rs2_busy);
  assign issue_go    = buf_valid && !stall && !flush;
  assign fetch_ready = !buf_valid;
  assign set_busy    = issue_go && rd_write_d;
  assign set_rd      = rd;

  always_ff @(posedge clk) begin
    if (reset) begin
      buf_valid   <= 1'b0;
      issue_valid <= 1'b0;
    end else begin
      issue_valid <= issue_go;
      if (flush || issue_go) begin
        buf_valid <= 1'b0;
      end else if (fetch_valid) begin
        buf_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_valid) begin
      buf_instr <= fetch_instr;
      buf_pc    <= fetch_pc;
    end
    if (issue_go) begin
      issue_pc       <= buf_pc;
      issue_a        <= rs1_data;
      issue_b        <= b_d;
      issue_imm      <= imm_d;
      issue_alu_op   <= alu_op_d;
      issue_rd       <= rd;
      issue_rd_write <= rd_write_d;
      issue_branch   <= branch_d;
      issue_jal      <= jal_d;
      issue_cond     <= cond_d;
    end
  end

endmodule

// ==== hdl/register_file.sv ====
module register_file #(
  parameter int XLEN = 64
) (
  input  logic               clk,
  input  logic               reset,
  input  core_pkg::reg_idx_t rs1,
  input  core_pkg::reg_idx_t rs2,
  input  logic               set_busy,
  input  core_pkg::reg_idx_t set_rd,
  input  logic               wb_valid,
  input  core_pkg::reg_idx_t wb_rd,
  input  logic [XLEN-1:0]    wb_data,
  output logic [XLEN-1:0]    rs1_data,
  output logic [XLEN-1:0]    rs2_data,
  output logic               rs1_busy,
  output logic               rs2_busy
);

  logic [XLEN-1:0] regs [32];
  logic [31:0]     busy;

  // x0 is never written and never marked, so it reads as zero and free
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];
  assign rs1_busy = busy[rs1];
  assign rs2_busy = busy[rs2];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_valid && wb_rd != 5'd0) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // Scoreboard
  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= '0;
    end else begin
      if (wb_valid && wb_rd != 5'd0) begin
        busy[wb_rd] <= 1'b0;
      end
      // A new owner of the same register wins over the retiring one
      if (set_busy && set_rd != 5'd0) begin
        busy[set_rd] <= 1'b1;
      end
    end
  end

endmodule

// ==== hdl/execute_unit.sv ====
module execute_unit #(
  parameter int XLEN = 64
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   issue_valid,
  input  logic [XLEN-1:0]        issue_pc,
  input  logic [XLEN-1:0]        issue_a,
  input  logic [XLEN-1:0]        issue_b,
  input  logic [XLEN-1:0]        issue_imm,
  input  core_pkg::alu_op_t      issue_alu_op,
  input  core_pkg::reg_idx_t     issue_rd,
  input  logic                   issue_rd_write,
  input  logic                   issue_branch,
  input  logic                   issue_jal,
  input  core_pkg::branch_cond_t issue_cond,
  output logic                   flush,
  output logic [XLEN-1:0]        flush_target,
  output logic                   wb_valid,
  output core_pkg::reg_idx_t     wb_rd,
  output logic [XLEN-1:0]        wb_data
);

  logic [XLEN-1:0] alu_result;
  logic [XLEN-1:0] link;
  logic            cond_true;
  logic            taken;

  always_comb begin
    case (issue_alu_op)
      core_pkg::ALU_ADD:  alu_result = issue_a + issue_b;
      core_pkg::ALU_SUB:  alu_result = issue_a - issue_b;
      core_pkg::ALU_AND:  alu_result = issue_a & issue_b;
      core_pkg::ALU_OR:   alu_result = issue_a | issue_b;
      core_pkg::ALU_XOR:  alu_result = issue_a ^ issue_b;
      core_pkg::ALU_SLT:  alu_result = XLEN'($signed(issue_a) < $signed(issue_b));
      core_pkg::ALU_PASS: alu_result = issue_imm;
      default:            alu_result = '0;
    endcase
  end

  // Signed compare for BLT
  always_comb begin
    case (issue_cond)
      core_pkg::BR_EQ: cond_true = (issue_a == issue_b);
      core_pkg::BR_NE: cond_true = (issue_a != issue_b);
      core_pkg::BR_LT: cond_true = ($signed(issue_a) < $signed(issue_b));
      default:         cond_true = 1'b0;
    endcase
  end

  assign link  = issue_pc + XLEN'(4);
  assign taken = issue_jal || (issue_branch && cond_true);

  always_ff @(posedge clk) begin
    if (reset) begin
      flush    <= 1'b0;
      wb_valid <= 1'b0;
    end else begin
      flush    <= issue_valid && taken;
      wb_valid <= issue_valid && issue_rd_write;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid) begin
      flush_target <= issue_pc + issue_imm;
      wb_rd        <= issue_rd;
      wb_data      <= issue_jal ? link : alu_result;
    end
  end

endmodule

// ==== hdl/core_top.sv ====
module core_top #(
  parameter int XLEN = 64
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [XLEN-1:0]              entry,
  output logic                         imem_req,
  output logic [XLEN-1:0]              imem_addr,
  input  logic                         imem_valid,
  input  logic [core_pkg::INSTR_W-1:0] imem_data,
  output logic                         wb_valid,
  output core_pkg::reg_idx_t           wb_rd,
  output logic [XLEN-1:0]              wb_data
);

  // Fetch to decode
  logic                         fetch_valid;
  logic [core_pkg::INSTR_W-1:0] fetch_instr;
  logic [XLEN-1:0]              fetch_pc;
  logic                         fetch_ready;

  // Decode to register file
  core_pkg::reg_idx_t rs1;
  core_pkg::reg_idx_t rs2;
  logic [XLEN-1:0]    rs1_data;
  logic [XLEN-1:0]    rs2_data;
  logic               rs1_busy;
  logic               rs2_busy;
  logic               set_busy;
  core_pkg::reg_idx_t set_rd;

  // Issue register
  logic                   issue_valid;
  logic [XLEN-1:0]        issue_pc;
  logic [XLEN-1:0]        issue_a;
  logic [XLEN-1:0]        issue_b;
  logic [XLEN-1:0]        issue_imm;
  core_pkg::alu_op_t      issue_alu_op;
  core_pkg::reg_idx_t     issue_rd;
  logic                   issue_rd_write;
  logic                   issue_branch;
  logic                   issue_jal;
  core_pkg::branch_cond_t issue_cond;

  // Redirect
  logic            flush;
  logic [XLEN-1:0] flush_target;

  fetch_unit #(.XLEN(XLEN)) u_fetch (
    .clk          (clk),
    .reset        (reset),
    .entry        (entry),
    .imem_valid   (imem_valid),
    .imem_data    (imem_data),
    .fetch_ready  (fetch_ready),
    .flush        (flush),
    .flush_target (flush_target),
    .imem_req     (imem_req),
    .imem_addr    (imem_addr),
    .fetch_valid  (fetch_valid),
    .fetch_instr  (fetch_instr),
    .fetch_pc     (fetch_pc)
  );

  decode_unit #(.XLEN(XLEN)) u_decode (
    .clk            (clk),
    .reset          (reset),
    .fetch_valid    (fetch_valid),
    .fetch_instr    (fetch_instr),
    .fetch_pc       (fetch_pc),
    .flush          (flush),
    .rs1_data       (rs1_data),
    .rs2_data       (rs2_data),
    .rs1_busy       (rs1_busy),
    .rs2_busy       (rs2_busy),
    .fetch_ready    (fetch_ready),
    .rs1            (rs1),
    .rs2            (rs2),
    .set_busy       (set_busy),
    .set_rd         (set_rd),
    .issue_valid    (issue_valid),
    .issue_pc       (issue_pc),
    .issue_a        (issue_a),
    .issue_b        (issue_b),
    .issue_imm      (issue_imm),
    .issue_alu_op   (issue_alu_op),
    .issue_rd       (issue_rd),
    .issue_rd_write (issue_rd_write),
    .issue_branch   (issue_branch),
    .issue_jal      (issue_jal),
    .issue_cond     (issue_cond)
  );

  register_file #(.XLEN(XLEN)) u_regs (
    .clk      (clk),
    .reset    (reset),
    .rs1      (rs1),
    .rs2      (rs2),
    .set_busy (set_busy),
    .set_rd   (set_rd),
    .wb_valid (wb_valid),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rs1_busy (rs1_busy),
    .rs2_busy (rs2_busy)
  );

  execute_unit #(.XLEN(XLEN)) u_execute (
    .clk            (clk),
    .reset          (reset),
    .issue_valid    (issue_valid),
    .issue_pc       (issue_pc),
    .issue_a        (issue_a),
    .issue_b        (issue_b),
    .issue_imm      (issue_imm),
    .issue_alu_op   (issue_alu_op),
    .issue_rd       (issue_rd),
    .issue_rd_write (issue_rd_write),
    .issue_branch   (issue_branch),
    .issue_jal      (issue_jal),
    .issue_cond     (issue_cond),
    .flush          (flush),
    .flush_target   (flush_target),
    .wb_valid       (wb_valid),
    .wb_rd          (wb_rd),
    .wb_data        (wb_data)
  );

endmodule

// ==== dv/clock_gen.sv ====
module clock_gen (
  output logic clk,
  output logic reset
);
  timeunit 1ns;
  timeprecision 1ps;

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Reset for ten cycles, released on a falling edge
  initial begin
    reset = 1'b1;
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

// ==== dv/core_tb.sv ====
module core_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int XLEN         = 64;
  localparam int TEST_WORDS   = 512;
  localparam int MEM_WORDS    = 1024;
  localparam int MAX_EXPECT   = 128;
  localparam int DRAIN_CYCLES = 30;

  logic            clk;
  logic            reset;
  logic [XLEN-1:0] entry;
  logic            imem_req;
  logic [XLEN-1:0] imem_addr;
  logic            imem_valid;
  logic [31:0]     imem_data;
  logic            wb_valid;
  logic [4:0]      wb_rd;
  logic [XLEN-1:0] wb_data;

  // Raw records from the data file, then the program and expected write-backs
  logic [63:0]     test_words [TEST_WORDS];
  logic [31:0]     mem_words [MEM_WORDS];
  logic            mem_present [MEM_WORDS];
  logic [4:0]      exp_rd [MAX_EXPECT];
  logic [XLEN-1:0] exp_data [MAX_EXPECT];

  int              n_expect   = 0;
  int              n_seen     = 0;
  int              errors     = 0;
  int              mismatches = 0;
  int              cycles     = 0;
  int              limit      = 0;
  int              wait_cnt   = 0;
  int              latency;
  integer          seed       = 32'h7a67_5451;
  logic [XLEN-1:0] resp_addr;

  clock_gen clocks (
    .clk   (clk),
    .reset (reset)
  );

  core_top #(.XLEN(XLEN)) uut (
    .clk        (clk),
    .reset      (reset),
    .entry      (entry),
    .imem_req   (imem_req),
    .imem_addr  (imem_addr),
    .imem_valid (imem_valid),
    .imem_data  (imem_data),
    .wb_valid   (wb_valid),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data)
  );

  // Unmapped addresses read as ADDI x0, x0 with an immediate folded from the address
  function automatic logic [31:0] instr_at(input logic [63:0] addr);
    logic [11:0] fold;
    logic [31:0] word;
    fold = addr[11:0] ^ addr[23:12] ^ addr[35:24] ^ addr[47:36] ^ addr[59:48] ^
           {8'h00, addr[63:60]};
    if (addr[63:12] == '0 && mem_present[addr[11:2]]) begin
      word = mem_words[addr[11:2]];
    end else begin
      word = {fold, 20'h00013};
    end
    return word;
  endfunction

  task automatic load_tests();
    int          i;
    logic [63:0] tag;
    logic [63:0] a;
    logic [63:0] b;
    bit          have_entry;
    for (i = 0; i < TEST_WORDS; i++) begin
      test_words[i] = '0;
    end
    for (i = 0; i < MEM_WORDS; i++) begin
      mem_present[i] = 1'b0;
    end
    $readmemh("dv/core_tests.txt", test_words);
    have_entry = 1'b0;
    i = 0;
    // Three words per record, a zero tag ends the list
    while (i + 2 < TEST_WORDS && test_words[i] != '0) begin
      tag = test_words[i];
      a   = test_words[i + 1];
      b   = test_words[i + 2];
      case (tag)
        64'd1: begin
          entry      = a;
          have_entry = 1'b1;
        end
        64'd2: begin
          if (a < MEM_WORDS) begin
            mem_words[a]   = b[31:0];
            mem_present[a] = 1'b1;
          end else begin
            $display("ERROR: program word address %h is outside the memory model", a);
            errors++;
          end
        end
        64'd3: begin
          if (n_expect < MAX_EXPECT) begin
            exp_rd[n_expect]   = a[4:0];
            exp_data[n_expect] = b;
            n_expect++;
          end else begin
            $display("ERROR: too many expected write-backs in the test file");
            errors++;
          end
        end
        default: begin
          $display("ERROR: unknown record tag %h at word %0d of the test file", tag, i);
          errors++;
        end
      endcase
      i += 3;
    end
    if (!have_entry) begin
      $display("ERROR: the test file gives no entry address");
      errors++;
    end
    if (n_expect == 0) begin
      $display("ERROR: the test file gives no expected write-backs");
      errors++;
    end
  endtask

  task automatic check_writeback();
    if (n_seen >= n_expect) begin
      $display("ERROR: write-back to x%0d with data %h came after the expected list ended",
               wb_rd, wb_data);
      errors++;
    end else begin
      if (wb_rd !== exp_rd[n_seen]) begin
        $display("MISMATCH wb_rd: expected %h, got %h at write-back %0d",
                 exp_rd[n_seen], wb_rd, n_seen);
        mismatches++;
        errors++;
      end
      if (wb_data !== exp_data[n_seen]) begin
        $display("MISMATCH wb_data: expected %h, got %h at write-back %0d",
                 exp_data[n_seen], wb_data, n_seen);
        mismatches++;
        errors++;
      end
      n_seen++;
    end
  endtask

  // Instruction memory, accepts a request on the rising edge
  always @(posedge clk) begin
    if (!reset && imem_req) begin
      if (wait_cnt != 0) begin
        $display("ERROR: instruction request for %h while another is outstanding",
                 imem_addr);
        errors++;
      end
      resp_addr = imem_addr;
      latency   = $random(seed);
      wait_cnt  = 1 + (latency & 3);
    end
  end

  // Response pulse driven on the falling edge
  always @(negedge clk) begin
    imem_valid = 1'b0;
    if (wait_cnt != 0) begin
      wait_cnt--;
      if (wait_cnt == 0) begin
        imem_valid = 1'b1;
        imem_data  = instr_at(resp_addr);
      end
    end
  end

  initial begin
    entry      = '0;
    imem_valid = 1'b0;
    imem_data  = '0;
    load_tests();
    limit = 40 * n_expect + 100;

    wait (reset === 1'b1);
    wait (reset === 1'b0);

    while (n_seen < n_expect && cycles < limit) begin
      @(negedge clk);
      cycles++;
      if (wb_valid) begin
        check_writeback();
      end
    end

    if (n_seen < n_expect) begin
      $display("ERROR: run timed out after %0d cycles with %0d of %0d write-backs seen",
               cycles, n_seen, n_expect);
      errors++;
    end else begin
      // Watch a while longer for stray write-backs
      repeat (DRAIN_CYCLES) begin
        @(negedge clk);
        if (wb_valid) begin
          check_writeback();
        end
      end
    end

    $display("Summary: %0d of %0d write-backs checked, %0d mismatches, %0d errors",
             n_seen, n_expect, mismatches, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
hdl/core_pkg.sv
hdl/fetch_unit.sv
hdl/decode_unit.sv
hdl/register_file.sv
hdl/execute_unit.sv
hdl/core_top.sv
dv/clock_gen.sv
dv/core_tb.sv

// ==== dv/core_tests.txt ====
// Records of three hex words: tag, a, b. Tag 1 entry (a = byte address),
// tag 2 program (a = word address, b = instruction), tag 3 expected (a = rd, b = value)
1 100 0
2 40 00500093 // addi x1, x0, 5
2 41 ffd00113 // addi x2, x0, -3
2 42 002081b3 // add x3, x1, x2
2 43 40208233 // sub x4, x1, x2
2 44 0f01c293 // xori x5, x3, 0xf0
2 45 7002e313 // ori x6, x5, 0x700
2 46 0ff37393 // andi x7, x6, 0xff
2 47 00237433 // and x8, x6, x2
2 48 0040e4b3 // or x9, x1, x4
2 49 0014c533 // xor x10, x9, x1
2 4a 001125b3 // slt x11, x2, x1
2 4b 0020a633 // slt x12, x1, x2
2 4c 800006b7 // lui x13, 0x80000
2 4d 00708013 // addi x0, x1, 7
2 4e 00450663 // beq x10, x4, +12 taken
2 4f 00100713 // addi x14, x0, 1 skipped
2 50 00200793 // addi x15, x0, 2 skipped
2 51 12300813 // addi x16, x0, 0x123
2 52 00109463 // bne x1, x1, +8 not taken
2 53 00180893 // addi x17, x16, 1
2 54 00114663 // blt x2, x1, +12 taken
2 55 00300913 // addi x18, x0, 3 skipped
2 56 00400993 // addi x19, x0, 4 skipped
2 57 01000a6f // jal x20, +16
2 58 00500a93 // addi x21, x0, 5 skipped
2 59 00600b13 // addi x22, x0, 6 skipped
2 5a 00700b93 // addi x23, x0, 7 skipped
2 5b 011a0c33 // add x24, x20, x17
2 5c 00208463 // beq x1, x2, +8 not taken
2 5d 0080006f // jal x0, +8
2 5e 00900c93 // addi x25, x0, 9 skipped
2 5f ffcc0d13 // addi x26, x24, -4
2 60 0020c463 // blt x1, x2, +8 not taken
2 61 40d00db3 // sub x27, x0, x13
2 62 12345e37 // lui x28, 0x12345
2 63 678e0e93 // addi x29, x28, 0x678
2 64 0000006f // jal x0, 0 spins here
3 1 5
3 2 fffffffffffffffd
3 3 2
3 4 8
3 5 f2
3 6 7f2
3 7 f2
3 8 7f0
3 9 d
3 a 8
3 b 1
3 c 0
3 d ffffffff80000000
3 10 123
3 11 124
3 14 160
3 18 284
3 1a 280
3 1b 80000000
3 1c 12345000
3 1d 12345678
